//--- gecko_pkg.sv
// shared types and decode constants for the gecko decode stage, imported by each design file
package gecko_pkg;

    // register file geometry
    localparam int GECKO_REG_COUNT      = 32;
    localparam int GECKO_REG_ADDR_WIDTH = $clog2(GECKO_REG_COUNT);
    localparam int GECKO_REG_WIDTH      = 32;

    // two bits of outstanding writes per register
    localparam int GECKO_STATUS_WIDTH = 2;

    localparam int GECKO_INSTR_WIDTH = 32;

    typedef logic [GECKO_REG_ADDR_WIDTH-1:0] gecko_reg_addr_t;
    typedef logic [GECKO_REG_WIDTH-1:0]      gecko_reg_value_t;

    // counter wraps, so differences are taken modulo 4
    typedef logic [GECKO_STATUS_WIDTH-1:0] gecko_reg_status_t;

    typedef logic [GECKO_INSTR_WIDTH-1:0] gecko_instruction_t;

    // issue holds back a writer once this many writes are pending
    localparam gecko_reg_status_t GECKO_STATUS_MAX = 2'd3;

    // x0 reads as zero and is never reserved
    localparam gecko_reg_addr_t GECKO_REG_ZERO = '0;

    // instruction field positions, standard RV32 layout
    localparam int GECKO_OPCODE_WIDTH = 7;
    localparam int GECKO_RD_LSB       = 7;
    localparam int GECKO_RS1_LSB      = 15;
    localparam int GECKO_RS2_LSB      = 20;

    // major opcodes handled by this decode stage
    typedef enum logic [GECKO_OPCODE_WIDTH-1:0] {
        // register-immediate alu ops
        GECKO_OP_IMM   = 7'b0010011,
        // stores read both sources, no destination
        GECKO_OP_STORE = 7'b0100011,
        // register-register alu ops
        GECKO_OP_REG   = 7'b0110011,
        // upper immediate, destination only
        GECKO_OP_LUI   = 7'b0110111
    } gecko_opcode_t;

endpackage

//--- gecko_regfile_if.sv
// source read and destination reservation bundle between the issue controller and register file
interface gecko_regfile_if;

    import gecko_pkg::*;

    // driven by issue
    gecko_reg_addr_t   rs1_addr;
    gecko_reg_addr_t   rs2_addr;
    logic              reserve_enable;
    gecko_reg_addr_t   reserve_addr;

    // driven by the register file, combinational on the addresses above
    gecko_reg_value_t  rs1_value;
    gecko_reg_value_t  rs2_value;
    gecko_reg_status_t rs1_status;
    gecko_reg_status_t rs2_status;
    // tag of the newest pending writer of each source
    gecko_reg_status_t rs1_front_last;
    gecko_reg_status_t rs2_front_last;
    gecko_reg_status_t rd_status;
    // front counter of reserve_addr, becomes the tag of a new reservation
    gecko_reg_status_t rd_front;
    logic              reset_done;

    modport issue (
        output rs1_addr, rs2_addr, reserve_enable, reserve_addr,
        input  rs1_value, rs2_value, rs1_status, rs2_status,
        input  rs1_front_last, rs2_front_last, rd_status, rd_front, reset_done
    );

    modport regfile (
        input  rs1_addr, rs2_addr, reserve_enable, reserve_addr,
        output rs1_value, rs2_value, rs1_status, rs2_status,
        output rs1_front_last, rs2_front_last, rd_status, rd_front, reset_done
    );

endinterface

//--- mem_combinational.sv
// flop memory with zero-latency read ports and a read-modify-write port, cleared by a sweep
module mem_combinational #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 5,
    parameter int READ_PORTS = 2
) (
    input  logic clk,
    input  logic rst_n,

    // write port, also reads its own address for read-modify-write
    input  logic                  write_enable,
    input  logic [ADDR_WIDTH-1:0] write_addr,
    input  logic [DATA_WIDTH-1:0] write_data_in,
    output logic [DATA_WIDTH-1:0] write_data_out,

    input  logic [READ_PORTS-1:0][ADDR_WIDTH-1:0] read_addr,
    output logic [READ_PORTS-1:0][DATA_WIDTH-1:0] read_data_out,

    output logic reset_done
);

    logic [DATA_WIDTH-1:0] entries [2**ADDR_WIDTH];

    // address being cleared while the sweep runs
    logic [ADDR_WIDTH-1:0] sweep_addr;

    // one entry per clock, done after the last address
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sweep_addr <= '0;
            reset_done <= 1'b0;
        end else if (!reset_done) begin
            sweep_addr <= sweep_addr + 1'b1;
            if (&sweep_addr) begin
                reset_done <= 1'b1;
            end
        end
    end

    // writes from the port are dropped until the sweep is over
    always_ff @(posedge clk) begin
        if (!reset_done) begin
            entries[sweep_addr] <= '0;
        end else if (write_enable) begin
            entries[write_addr] <= write_data_in;
        end
    end

    always_comb begin
        for (int i = 0; i < READ_PORTS; i++) begin
            read_data_out[i] = entries[read_addr[i]];
        end
    end

    // old contents at the write address, new data lands at the edge
    always_comb begin
        write_data_out = entries[write_addr];
    end

endmodule

//--- gecko_decode_regfile.sv
// register values plus front and rear write counters, gives per-register readiness to issue
module gecko_decode_regfile (
    input  logic clk,
    input  logic rst_n,

    // writeback from the environment
    input  logic                       wb_enable,
    input  logic                       wb_value_enable,
    input  gecko_pkg::gecko_reg_addr_t  wb_addr,
    input  gecko_pkg::gecko_reg_value_t wb_value,

    gecko_regfile_if.regfile rf
);

    import gecko_pkg::*;

    logic wb_nonzero;
    logic value_done;
    logic front_done;
    logic rear_done;

    gecko_reg_status_t rd_front;
    gecko_reg_status_t rs1_front;
    gecko_reg_status_t rs2_front;

    gecko_reg_status_t wb_rear;
    gecko_reg_status_t rd_rear;
    gecko_reg_status_t rs1_rear;
    gecko_reg_status_t rs2_rear;

    // x0 is hardwired, writebacks to it change nothing
    assign wb_nonzero = (wb_addr != GECKO_REG_ZERO);

    mem_combinational #(
        .DATA_WIDTH ($bits(gecko_reg_value_t)),
        .ADDR_WIDTH (GECKO_REG_ADDR_WIDTH),
        .READ_PORTS (2)
    ) i_value_mem (
        .clk            (clk),
        .rst_n          (rst_n),
        .write_enable   (wb_value_enable && wb_nonzero),
        .write_addr     (wb_addr),
        .write_data_in  (wb_value),
        .write_data_out (),
        .read_addr      ({rf.rs1_addr, rf.rs2_addr}),
        .read_data_out  ({rf.rs1_value, rf.rs2_value}),
        .reset_done     (value_done)
    );

    // front counter moves when issue reserves a destination
    mem_combinational #(
        .DATA_WIDTH ($bits(gecko_reg_status_t)),
        .ADDR_WIDTH (GECKO_REG_ADDR_WIDTH),
        .READ_PORTS (2)
    ) i_front_mem (
        .clk            (clk),
        .rst_n          (rst_n),
        .write_enable   (rf.reserve_enable),
        .write_addr     (rf.reserve_addr),
        .write_data_in  (rd_front + 2'd1),
        .write_data_out (rd_front),
        .read_addr      ({rf.rs1_addr, rf.rs2_addr}),
        .read_data_out  ({rs1_front, rs2_front}),
        .reset_done     (front_done)
    );

    // rear counter moves when a writeback completes
    mem_combinational #(
        .DATA_WIDTH ($bits(gecko_reg_status_t)),
        .ADDR_WIDTH (GECKO_REG_ADDR_WIDTH),
        .READ_PORTS (3)
    ) i_rear_mem (
        .clk            (clk),
        .rst_n          (rst_n),
        .write_enable   (wb_enable && wb_nonzero),
        .write_addr     (wb_addr),
        .write_data_in  (wb_rear + 2'd1),
        .write_data_out (wb_rear),
        .read_addr      ({rf.reserve_addr, rf.rs1_addr, rf.rs2_addr}),
        .read_data_out  ({rd_rear, rs1_rear, rs2_rear}),
        .reset_done     (rear_done)
    );

    // all three sweeps run in lockstep
    assign rf.reset_done = value_done && front_done && rear_done;

    // pending writes, zero means the file holds the current value
    assign rf.rs1_status = rs1_front - rs1_rear;
    assign rf.rs2_status = rs2_front - rs2_rear;
    assign rf.rd_status  = rd_front - rd_rear;

    // forwarded results carry the front value their producer was given
    assign rf.rs1_front_last = rs1_front - 2'd1;
    assign rf.rs2_front_last = rs2_front - 2'd1;
    assign rf.rd_front       = rd_front;

endmodule

//--- gecko_decode_issue.sv
// decodes one instruction, checks operand hazards, takes forwards and issues operands a cycle later
module gecko_decode_issue (
    input  logic clk,
    input  logic rst_n,

    input  logic                          instruction_valid,
    input  gecko_pkg::gecko_instruction_t instruction,
    output logic                          instruction_ready,
    output logic                          illegal,

    // results from execute that have not reached the file yet
    input  logic                          fwd_valid,
    input  gecko_pkg::gecko_reg_addr_t    fwd_addr,
    input  gecko_pkg::gecko_reg_status_t  fwd_tag,
    input  gecko_pkg::gecko_reg_value_t   fwd_value,

    output logic                          issue_valid,
    output gecko_pkg::gecko_opcode_t      issue_opcode,
    output gecko_pkg::gecko_reg_addr_t    issue_rd,
    output gecko_pkg::gecko_reg_status_t  issue_rd_tag,
    output gecko_pkg::gecko_reg_value_t   issue_rs1_value,
    output gecko_pkg::gecko_reg_value_t   issue_rs2_value,

    gecko_regfile_if.issue rf
);

    import gecko_pkg::*;

    gecko_opcode_t    opcode;
    gecko_reg_addr_t  rd;
    gecko_reg_addr_t  rs1;
    gecko_reg_addr_t  rs2;

    logic opcode_known;
    logic uses_rs1;
    logic uses_rs2;
    logic writes_rd;
    logic rd_reserve;

    logic rs1_fwd;
    logic rs2_fwd;
    logic rs1_ready;
    logic rs2_ready;
    logic rd_ready;
    logic accept;

    gecko_reg_value_t rs1_value;
    gecko_reg_value_t rs2_value;

    // field split
    always_comb begin
        opcode = gecko_opcode_t'(instruction[GECKO_OPCODE_WIDTH-1:0]);
        rd     = instruction[GECKO_RD_LSB +: GECKO_REG_ADDR_WIDTH];
        rs1    = instruction[GECKO_RS1_LSB +: GECKO_REG_ADDR_WIDTH];
        rs2    = instruction[GECKO_RS2_LSB +: GECKO_REG_ADDR_WIDTH];
    end

    // which operands each opcode needs
    always_comb begin
        opcode_known = 1'b1;
        uses_rs1     = 1'b0;
        uses_rs2     = 1'b0;
        writes_rd    = 1'b0;
        case (opcode)
            GECKO_OP_REG: begin
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                writes_rd = 1'b1;
            end
            GECKO_OP_IMM: begin
                uses_rs1  = 1'b1;
                writes_rd = 1'b1;
            end
            GECKO_OP_LUI: begin
                writes_rd = 1'b1;
            end
            GECKO_OP_STORE: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            default: begin
                opcode_known = 1'b0;
            end
        endcase
    end

    assign rd_reserve = writes_rd && (rd != GECKO_REG_ZERO);

    // a forward only helps when it is the single outstanding write
    assign rs1_fwd = fwd_valid && (fwd_addr == rs1) && (fwd_tag == rf.rs1_front_last)
                     && (rf.rs1_status == 2'd1);
    assign rs2_fwd = fwd_valid && (fwd_addr == rs2) && (fwd_tag == rf.rs2_front_last)
                     && (rf.rs2_status == 2'd1);

    assign rs1_ready = !uses_rs1 || (rf.rs1_status == '0) || rs1_fwd;
    assign rs2_ready = !uses_rs2 || (rf.rs2_status == '0) || rs2_fwd;
    assign rd_ready  = !rd_reserve || (rf.rd_status < GECKO_STATUS_MAX);

    assign instruction_ready = rf.reset_done && rs1_ready && rs2_ready && rd_ready;
    assign accept            = instruction_valid && instruction_ready;

    assign rf.rs1_addr       = rs1;
    assign rf.rs2_addr       = rs2;
    assign rf.reserve_addr   = rd;
    // writes_rd is low for unknown opcodes, so illegal ones reserve nothing
    assign rf.reserve_enable = accept && rd_reserve;

    // operand select, unused sources go out as zero
    always_comb begin
        if (!uses_rs1) begin
            rs1_value = '0;
        end else if (rs1_fwd) begin
            rs1_value = fwd_value;
        end else begin
            rs1_value = rf.rs1_value;
        end
        if (!uses_rs2) begin
            rs2_value = '0;
        end else if (rs2_fwd) begin
            rs2_value = fwd_value;
        end else begin
            rs2_value = rf.rs2_value;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_valid <= 1'b0;
            illegal     <= 1'b0;
        end else begin
            issue_valid <= accept && opcode_known;
            illegal     <= accept && !opcode_known;
        end
    end

    // the tag is the front count before this reservation bumps it
    always_ff @(posedge clk) begin
        if (accept) begin
            issue_opcode    <= opcode;
            issue_rd        <= rd;
            issue_rd_tag    <= rf.rd_front;
            issue_rs1_value <= rs1_value;
            issue_rs2_value <= rs2_value;
        end
    end

endmodule

//--- gecko_decode.sv
// decode stage top level, joins the issue controller to the register file behind plain ports
module gecko_decode (
    input  logic clk,
    input  logic rst_n,

    input  logic                          instruction_valid,
    input  gecko_pkg::gecko_instruction_t instruction,
    output logic                          instruction_ready,
    output logic                          illegal,

    // writeback side of execute
    input  logic                          wb_enable,
    input  logic                          wb_value_enable,
    input  gecko_pkg::gecko_reg_addr_t    wb_addr,
    input  gecko_pkg::gecko_reg_value_t   wb_value,

    input  logic                          fwd_valid,
    input  gecko_pkg::gecko_reg_addr_t    fwd_addr,
    input  gecko_pkg::gecko_reg_status_t  fwd_tag,
    input  gecko_pkg::gecko_reg_value_t   fwd_value,

    output logic                          issue_valid,
    output gecko_pkg::gecko_opcode_t      issue_opcode,
    output gecko_pkg::gecko_reg_addr_t    issue_rd,
    output gecko_pkg::gecko_reg_status_t  issue_rd_tag,
    output gecko_pkg::gecko_reg_value_t   issue_rs1_value,
    output gecko_pkg::gecko_reg_value_t   issue_rs2_value
);

    gecko_regfile_if rf_if ();

    gecko_decode_issue i_gecko_decode_issue (
        .clk               (clk),
        .rst_n             (rst_n),
        .instruction_valid (instruction_valid),
        .instruction       (instruction),
        .instruction_ready (instruction_ready),
        .illegal           (illegal),
        .fwd_valid         (fwd_valid),
        .fwd_addr          (fwd_addr),
        .fwd_tag           (fwd_tag),
        .fwd_value         (fwd_value),
        .issue_valid       (issue_valid),
        .issue_opcode      (issue_opcode),
        .issue_rd          (issue_rd),
        .issue_rd_tag      (issue_rd_tag),
        .issue_rs1_value   (issue_rs1_value),
        .issue_rs2_value   (issue_rs2_value),
        .rf                (rf_if.issue)
    );

    gecko_decode_regfile i_gecko_decode_regfile (
        .clk             (clk),
        .rst_n           (rst_n),
        .wb_enable       (wb_enable),
        .wb_value_enable (wb_value_enable),
        .wb_addr         (wb_addr),
        .wb_value        (wb_value),
        .rf              (rf_if.regfile)
    );

endmodule

//--- gecko_decode_tb.sv
// testbench for the decode stage, plays execute and writeback against a register model
module gecko_decode_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import gecko_pkg::*;

    // well above the length of the directed tests
    localparam int CYCLE_LIMIT  = 2000;
    localparam int ACCEPT_LIMIT = 100;

    logic               clk;
    logic               rst_n;
    logic               instruction_valid;
    gecko_instruction_t instruction;
    logic               instruction_ready;
    logic               illegal;
    logic               wb_enable;
    logic               wb_value_enable;
    gecko_reg_addr_t    wb_addr;
    gecko_reg_value_t   wb_value;
    logic               fwd_valid;
    gecko_reg_addr_t    fwd_addr;
    gecko_reg_status_t  fwd_tag;
    gecko_reg_value_t   fwd_value;
    logic               issue_valid;
    gecko_opcode_t      issue_opcode;
    gecko_reg_addr_t    issue_rd;
    gecko_reg_status_t  issue_rd_tag;
    gecko_reg_value_t   issue_rs1_value;
    gecko_reg_value_t   issue_rs2_value;

    // reference model, outstanding writes are front minus rear
    gecko_reg_value_t  model_value [GECKO_REG_COUNT];
    gecko_reg_status_t model_front [GECKO_REG_COUNT];
    gecko_reg_status_t model_rear  [GECKO_REG_COUNT];

    logic [31:0] lcg_state;
    int          cycle_count;

    gecko_decode i_gecko_decode (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            abort_run($sformatf("timeout, run still going after %0d cycles", cycle_count));
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input gecko_reg_value_t exp,
            input gecko_reg_value_t act);
        if (act !== exp) begin
            abort_run($sformatf("mismatch at %0d ns: %s expected %h actual %h",
                $time, name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input gecko_reg_addr_t exp,
            input gecko_reg_addr_t act);
        if (act !== exp) begin
            abort_run($sformatf("mismatch at %0d ns: %s expected %0d actual %0d",
                $time, name, exp, act));
        end
    endtask

    task automatic check_tag(input string name, input gecko_reg_status_t exp,
            input gecko_reg_status_t act);
        if (act !== exp) begin
            abort_run($sformatf("mismatch at %0d ns: %s expected %0d actual %0d",
                $time, name, exp, act));
        end
    endtask

    task automatic check_opcode(input string name, input gecko_opcode_t exp,
            input gecko_opcode_t act);
        if (act !== exp) begin
            abort_run($sformatf("mismatch at %0d ns: %s expected %h actual %h",
                $time, name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("mismatch at %0d ns: %s expected %b actual %b",
                $time, name, exp, act));
        end
    endtask

    // standard RV32 field layout, funct fields left at zero
    function automatic gecko_instruction_t make_instr(input logic [6:0] op,
            input gecko_reg_addr_t rd, input gecko_reg_addr_t rs1, input gecko_reg_addr_t rs2);
        return {7'd0, rs2, rs1, 3'd0, rd, op};
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // any register except x0
    function automatic gecko_reg_addr_t pick_reg();
        logic [31:0] r;
        r = lcg_next();
        return gecko_reg_addr_t'((r >> 16) % 32'd31) + 5'd1;
    endfunction

    task automatic present(input logic [6:0] op, input gecko_reg_addr_t rd,
            input gecko_reg_addr_t rs1, input gecko_reg_addr_t rs2);
        instruction       = make_instr(op, rd, rs1, rs2);
        instruction_valid = 1'b1;
    endtask

    // wait for ready, then let the accepting edge pass
    task automatic accept(input logic no_stall);
        int waited;
        waited = 0;
        @(negedge clk);
        if (no_stall) begin
            check_bit("instruction_ready", 1'b1, instruction_ready);
        end
        while (!instruction_ready) begin
            waited++;
            if (waited > ACCEPT_LIMIT) begin
                abort_run("instruction was never accepted by decode");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #5;
        instruction_valid = 1'b0;
        fwd_valid         = 1'b0;
    endtask

    task automatic check_issued(input gecko_opcode_t op, input gecko_reg_addr_t rd,
            input gecko_reg_value_t rs1_exp, input gecko_reg_value_t rs2_exp);
        check_bit("issue_valid", 1'b1, issue_valid);
        check_bit("illegal", 1'b0, illegal);
        check_opcode("issue_opcode", op, issue_opcode);
        check_addr("issue_rd", rd, issue_rd);
        check_tag("issue_rd_tag", model_front[rd], issue_rd_tag);
        check_value("issue_rs1_value", rs1_exp, issue_rs1_value);
        check_value("issue_rs2_value", rs2_exp, issue_rs2_value);
        // stores and x0 leave the front counter alone
        if (op != GECKO_OP_STORE && rd != GECKO_REG_ZERO) begin
            model_front[rd] = model_front[rd] + 2'd1;
        end
    endtask

    task automatic issue(input gecko_opcode_t op, input gecko_reg_addr_t rd,
            input gecko_reg_addr_t rs1, input gecko_reg_addr_t rs2,
            input gecko_reg_value_t rs1_exp, input gecko_reg_value_t rs2_exp);
        present(op, rd, rs1, rs2);
        accept(1'b0);
        check_issued(op, rd, rs1_exp, rs2_exp);
    endtask

    task automatic hold_stalled(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_bit("instruction_ready", 1'b0, instruction_ready);
            @(posedge clk);
            #5;
            check_bit("issue_valid", 1'b0, issue_valid);
        end
    endtask

    task automatic writeback(input gecko_reg_addr_t addr, input gecko_reg_value_t value);
        wb_enable       = 1'b1;
        wb_value_enable = 1'b1;
        wb_addr         = addr;
        wb_value        = value;
        @(posedge clk);
        #5;
        wb_enable       = 1'b0;
        wb_value_enable = 1'b0;
        model_value[addr] = value;
        model_rear[addr]  = model_rear[addr] + 2'd1;
    endtask

    // complete every write still pending in the model
    task automatic drain();
        for (int r = 1; r < GECKO_REG_COUNT; r++) begin
            while (model_front[r] != model_rear[r]) begin
                writeback(gecko_reg_addr_t'(r), lcg_next());
            end
        end
    endtask

    task automatic test_reset_sweep();
        present(GECKO_OP_REG, 5'd9, 5'd3, 5'd17);
        for (int i = 0; i < GECKO_REG_COUNT; i++) begin
            @(negedge clk);
            check_bit("instruction_ready", 1'b0, instruction_ready);
            check_bit("issue_valid", 1'b0, issue_valid);
        end
        accept(1'b1);
        check_issued(GECKO_OP_REG, 5'd9, '0, '0);
        drain();
    endtask

    task automatic test_writeback_read();
        gecko_reg_addr_t regs [8];
        logic            dup;
        // first four are sources, last four the readers' destinations
        for (int i = 0; i < 8; i++) begin
            do begin
                regs[i] = pick_reg();
                dup     = 1'b0;
                for (int j = 0; j < i; j++) begin
                    if (regs[j] == regs[i]) begin
                        dup = 1'b1;
                    end
                end
            end while (dup);
        end
        for (int i = 0; i < 4; i++) begin
            issue(GECKO_OP_LUI, regs[i], 5'd0, 5'd0, '0, '0);
        end
        for (int i = 0; i < 4; i++) begin
            writeback(regs[i], lcg_next());
        end
        for (int i = 0; i < 4; i++) begin
            issue(GECKO_OP_REG, regs[i + 4], regs[i], regs[(i + 1) % 4],
                model_value[regs[i]], model_value[regs[(i + 1) % 4]]);
        end
        @(posedge clk);
        #5;
        check_bit("issue_valid", 1'b0, issue_valid);
        drain();
    endtask

    task automatic test_raw_stall();
        gecko_reg_addr_t  src;
        gecko_reg_addr_t  other;
        gecko_reg_value_t value;
        src = pick_reg();
        do begin
            other = pick_reg();
        end while (other == src);
        issue(GECKO_OP_LUI, src, 5'd0, 5'd0, '0, '0);
        present(GECKO_OP_REG, 5'd0, src, other);
        hold_stalled(3);
        value = lcg_next();
        writeback(src, value);
        accept(1'b1);
        check_issued(GECKO_OP_REG, 5'd0, value, model_value[other]);
        drain();
    endtask

    task automatic test_forwarding();
        gecko_reg_addr_t   src;
        gecko_reg_status_t tag;
        gecko_reg_value_t  value;
        src   = pick_reg();
        value = lcg_next();
        issue(GECKO_OP_LUI, src, 5'd0, 5'd0, '0, '0);
        tag = issue_rd_tag;
        present(GECKO_OP_IMM, 5'd0, src, 5'd0);
        fwd_valid = 1'b1;
        fwd_addr  = src;
        fwd_tag   = tag + 2'd1;
        fwd_value = value;
        hold_stalled(2);
        // right tag, wrong register
        fwd_addr = src + 5'd1;
        fwd_tag  = tag;
        hold_stalled(2);
        fwd_addr = src;
        accept(1'b1);
        check_issued(GECKO_OP_IMM, 5'd0, value, '0);
        writeback(src, value);
        drain();
    endtask

    task automatic test_limit_tags();
        gecko_reg_addr_t   dst;
        gecko_reg_status_t first_tag;
        dst       = pick_reg();
        first_tag = model_front[dst];
        for (int i = 0; i < 3; i++) begin
            issue(GECKO_OP_LUI, dst, 5'd0, 5'd0, '0, '0);
        end
        check_tag("issue_rd_tag", first_tag + 2'd2, issue_rd_tag);
        present(GECKO_OP_LUI, dst, 5'd0, 5'd0);
        hold_stalled(2);
        writeback(dst, lcg_next());
        accept(1'b1);
        check_issued(GECKO_OP_LUI, dst, '0, '0);
        issue(GECKO_OP_LUI, 5'd0, 5'd0, 5'd0, '0, '0);
        present(GECKO_OP_REG, 5'd0, 5'd0, 5'd0);
        accept(1'b1);
        check_issued(GECKO_OP_REG, 5'd0, '0, '0);
        drain();
    endtask

    task automatic test_illegal_store();
        gecko_reg_addr_t src;
        gecko_reg_addr_t dst;
        src = pick_reg();
        do begin
            dst = pick_reg();
        end while (dst == src);
        issue(GECKO_OP_LUI, src, 5'd0, 5'd0, '0, '0);
        writeback(src, lcg_next());
        present(7'b1111111, src, src, src);
        accept(1'b0);
        check_bit("illegal", 1'b1, illegal);
        check_bit("issue_valid", 1'b0, issue_valid);
        present(GECKO_OP_IMM, 5'd0, src, 5'd0);
        accept(1'b1);
        check_issued(GECKO_OP_IMM, 5'd0, model_value[src], '0);
        issue(GECKO_OP_STORE, dst, src, dst, model_value[src], model_value[dst]);
        present(GECKO_OP_IMM, 5'd0, dst, 5'd0);
        accept(1'b1);
        check_issued(GECKO_OP_IMM, 5'd0, model_value[dst], '0);
        drain();
    endtask

    initial begin
        rst_n             = 1'b0;
        instruction_valid = 1'b0;
        instruction       = '0;
        wb_enable         = 1'b0;
        wb_value_enable   = 1'b0;
        wb_addr           = '0;
        wb_value          = '0;
        fwd_valid         = 1'b0;
        fwd_addr          = '0;
        fwd_tag           = '0;
        fwd_value         = '0;
        lcg_state         = 32'd59;
        for (int r = 0; r < GECKO_REG_COUNT; r++) begin
            model_value[r] = '0;
            model_front[r] = '0;
            model_rear[r]  = '0;
        end
        repeat (10) @(posedge clk);
        #5;
        rst_n = 1'b1;
        test_reset_sweep();
        test_writeback_read();
        test_raw_stall();
        test_forwarding();
        test_limit_tags();
        test_illegal_store();
        $display("** PASS **");
        $finish;
    end

endmodule

//--- list.f
gecko_pkg.sv
gecko_regfile_if.sv
mem_combinational.sv
gecko_decode_regfile.sv
gecko_decode_issue.sv
gecko_decode.sv
gecko_decode_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wall
TOP       ?= gecko_decode_tb
FILE_LIST ?= list.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST)

# the simulator exit status carries pass or fail
run: build
	./obj_dir/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf obj_dir
